// File: flist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/bus_pkg.sv
verilog/decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/sequencer.sv
verilog/cpu_top.sv
test/cpu_chk.sv
test/cpu_tb.sv

// File: Makefile
# Verilator build and run of the core testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/cpu_tb.sv
// Testbench for cpu_top
// Builds one short program per table row, runs each from reset and checks
// the memory writes against a 6502 reference model; optional rdy stalls
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_ROWS   = 16;
    localparam int          ROW_CYCLES = 40;
    localparam int          ROW_LIMIT  = 200;
    localparam logic [31:0] SEED       = 32'hf717_5139;
    localparam logic [15:0] ROW_CODE   = 16'h0400;
    // Target of the stores that every JMP jumps over
    localparam logic [15:0] PLANT_ADDR = 16'h07F0;

    // One row of stimulus; opcode A2 or A0 selects an index-register row
    typedef struct packed {
        logic        sec;
        logic [7:0]  load;
        logic [7:0]  opc;
        logic [7:0]  operand;
        logic [15:0] store;
        logic        stall;
    } row_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
    } wr_t;

    typedef struct packed {
        logic [7:0] a;
        logic [7:0] p;
    } ref_t;

    logic        phi0;
    logic        rst;
    logic        rdy;
    logic [7:0]  d_in;
    logic [15:0] a;
    logic [7:0]  d_out;
    logic        r_w_n;
    logic        sync;

    logic [7:0]  mem [0:65535];
    row_t        rows [NUM_ROWS];
    wr_t         writes [$];
    wr_t         expected [$];
    logic [15:0] build_pc;
    logic        stall_on;
    int          checks;
    int          errors;
    int          rows_run;

    cpu_top dut0 (
        .phi0(phi0), .rst(rst), .rdy(rdy), .d_in(d_in),
        .a(a), .d_out(d_out), .r_w_n(r_w_n), .sync(sync)
    );

    bind cpu_top cpu_chk cpu_chk (
        .phi0(phi0), .rst(rst), .rdy(rdy), .a(a),
        .d_out(d_out), .r_w_n(r_w_n), .sync(sync)
    );

    ////////////////////////////////////////////////////////////
    // Clock, stalls and memory
    ////////////////////////////////////////////////////////////

    initial begin
        phi0 = 1'b0;
        forever #(CLK_PERIOD / 2) phi0 = ~phi0;
    end

    // About one cycle in four stalled when enabled
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge phi0);
            #1;
            if (stall_on) rdy = ($urandom % 4) != 0;
            else rdy = 1'b1;
        end
    end

    assign d_in = mem[a];

    always @(posedge phi0) begin
        if (!rst && rdy && !r_w_n) begin
            writes.push_back(make_wr(a, d_out));
            mem[a] = d_out;
        end
    end

    always @(posedge phi0) begin
        if (rst && !r_w_n) begin
            $display("FAILED r_w_n during reset: got %h expected %h", r_w_n, 1'b1);
            errors++;
        end
    end

    initial begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD * 4);
        $display("Watchdog expired with %0d of %0d rows run", rows_run, NUM_ROWS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model and program builder
    ////////////////////////////////////////////////////////////

    function automatic wr_t make_wr(input logic [15:0] addr, input logic [7:0] data);
        wr_t w;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    // Binary-mode 6502 rules for the row's instruction sequence
    function automatic ref_t reference(input row_t r);
        ref_t       res;
        logic [8:0] wide;
        logic       n;
        logic       v;
        logic       z;
        logic       c;
        res.a = r.load;
        wide  = '0;
        v     = 1'b0;
        c     = r.sec;
        case (r.opc)
            8'h69: begin
                wide  = {1'b0, r.load} + {1'b0, r.operand} + {8'd0, r.sec};
                res.a = wide[7:0];
                c     = wide[8];
                v     = ((r.load ^ res.a) & (r.operand ^ res.a) & 8'h80) != 8'h00;
            end
            8'hE9: begin
                // Borrow is the inverted carry
                wide  = {1'b0, r.load} - {1'b0, r.operand} - {8'd0, ~r.sec};
                res.a = wide[7:0];
                c     = ~wide[8];
                v     = ((r.load ^ r.operand) & (r.load ^ res.a) & 8'h80) != 8'h00;
            end
            8'h29: res.a = r.load & r.operand;
            8'h09: res.a = r.load | r.operand;
            8'h49: res.a = r.load ^ r.operand;
            8'hC9: begin
                wide = {1'b0, r.load} - {1'b0, r.operand};
                c    = r.load >= r.operand;
            end
            // Index rows step up twice and down once to load plus one
            default: res.a = r.load + 8'd1;
        endcase
        n = res.a[7];
        z = (res.a == 8'h00);
        if (r.opc == 8'hC9) begin
            n = wide[7];
            z = (r.load == r.operand);
        end
        // Pushed P has B and bit 5 set with I still set from reset and D clear
        res.p = {n, v, 1'b1, 1'b1, 1'b0, 1'b1, z, c};
        return res;
    endfunction

    function automatic logic [15:0] row_base(input int idx);
        return ROW_CODE + 16'(idx * 32);
    endfunction

    task automatic emit(input logic [7:0] value);
        mem[build_pc] = value;
        build_pc = build_pc + 16'd1;
    endtask

    task automatic emit_abs(input logic [7:0] opc, input logic [15:0] addr);
        emit(opc);
        emit(addr[7:0]);
        emit(addr[15:8]);
    endtask

    task automatic build_row(input int idx);
        row_t r;
        logic x_row;
        r        = rows[idx];
        x_row    = (r.opc == 8'hA2);
        build_pc = row_base(idx);
        emit(r.sec ? 8'h38 : 8'h18);
        if (r.opc == 8'hA2 || r.opc == 8'hA0) begin
            emit(r.opc);
            emit(r.load);
            emit(x_row ? 8'hE8 : 8'hC8);
            emit(x_row ? 8'hE8 : 8'hC8);
            emit(x_row ? 8'hCA : 8'h88);
            emit(x_row ? 8'h8A : 8'h98);
        end else begin
            emit(8'hA9);
            emit(r.load);
            emit(r.opc);
            emit(r.operand);
        end
        emit_abs(8'h8D, r.store);
        emit(8'h08);
        emit(8'h08);
        emit_abs(8'h4C, row_base(idx + 1));
        emit_abs(8'h8D, PLANT_ADDR);
    endtask

    task automatic load_table();
        rows[0]  = '{1'b0, 8'h14, 8'h69, 8'h27, 16'h0700, 1'b0};
        rows[1]  = '{1'b1, 8'h7F, 8'h69, 8'h01, 16'h0701, 1'b0};
        rows[2]  = '{1'b0, 8'hFF, 8'h69, 8'h01, 16'h0702, 1'b0};
        rows[3]  = '{1'b1, 8'h50, 8'hE9, 8'h30, 16'h0703, 1'b0};
        rows[4]  = '{1'b0, 8'h50, 8'hE9, 8'hB0, 16'h0704, 1'b0};
        rows[5]  = '{1'b1, 8'hF0, 8'h29, 8'h3C, 16'h0705, 1'b0};
        rows[6]  = '{1'b0, 8'h80, 8'h09, 8'h01, 16'h0706, 1'b0};
        rows[7]  = '{1'b1, 8'h5A, 8'h49, 8'h5A, 16'h0707, 1'b0};
        rows[8]  = '{1'b0, 8'h40, 8'hC9, 8'h40, 16'h0708, 1'b0};
        rows[9]  = '{1'b1, 8'h10, 8'hC9, 8'h20, 16'h0709, 1'b0};
        rows[10] = '{1'b0, 8'h7F, 8'hA2, 8'h00, 16'h070A, 1'b0};
        rows[11] = '{1'b1, 8'hFF, 8'hA0, 8'h00, 16'h070B, 1'b0};
        // Stalled repeats of earlier rows expect the same writes
        rows[12] = '{1'b0, 8'h14, 8'h69, 8'h27, 16'h0700, 1'b1};
        rows[13] = '{1'b0, 8'h50, 8'hE9, 8'hB0, 16'h0704, 1'b1};
        rows[14] = '{1'b0, 8'h7F, 8'hA2, 8'h00, 16'h070A, 1'b1};
        rows[15] = '{1'b1, 8'h10, 8'hC9, 8'h20, 16'h0709, 1'b1};
    endtask

    ////////////////////////////////////////////////////////////
    // Row execution and checks
    ////////////////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge phi0);
        #1;
        rst = 1'b1;
        repeat (10) @(posedge phi0);
        #1;
        rst = 1'b0;
    endtask

    task automatic compare_writes(input int idx);
        int n;
        checks++;
        if (writes.size() != expected.size()) begin
            $display("Row %0d made %0d memory writes where %0d were expected",
                     idx, writes.size(), expected.size());
            errors++;
        end
        n = (writes.size() < expected.size()) ? writes.size() : expected.size();
        for (int i = 0; i < n; i++) begin
            checks += 2;
            if (writes[i].addr != expected[i].addr) begin
                $display("FAILED row %0d write %0d a: got %h expected %h",
                         idx, i, writes[i].addr, expected[i].addr);
                errors++;
            end
            if (writes[i].data != expected[i].data) begin
                $display("FAILED row %0d write %0d d_out: got %h expected %h",
                         idx, i, writes[i].data, expected[i].data);
                errors++;
            end
        end
    endtask

    task automatic run_row(input int idx);
        ref_t        want;
        logic [15:0] next;
        int          cycles;
        int          first_sync;
        int          err_before;
        logic        done;
        want       = reference(rows[idx]);
        next       = row_base(idx + 1);
        err_before = errors;
        // Trampoline at the reset PC with its own planted store
        build_pc = `CPU_RESET_PC;
        emit_abs(8'h4C, row_base(idx));
        emit_abs(8'h8D, PLANT_ADDR);
        stall_on = 1'b0;
        writes.delete();
        apply_reset();

        cycles     = 0;
        first_sync = 0;
        done       = 1'b0;
        while (!done && cycles < ROW_LIMIT) begin
            @(posedge phi0);
            cycles++;
            if (sync && first_sync == 0) begin
                first_sync = cycles;
                checks += 2;
                // One quiet cycle comes before the fetch
                if (cycles != 2) begin
                    $display("Row %0d first fetch came %0d cycles after reset, not 2",
                             idx, cycles);
                    errors++;
                end
                if (a != `CPU_RESET_PC) begin
                    $display("FAILED row %0d first fetch a: got %h expected %h",
                             idx, a, `CPU_RESET_PC);
                    errors++;
                end
                stall_on = rows[idx].stall;
            end
            if (sync && a == next) done = 1'b1;
        end
        stall_on = 1'b0;
        checks++;
        if (!done) begin
            $display("Row %0d never reached the next row's code within %0d cycles",
                     idx, ROW_LIMIT);
            errors++;
        end

        expected.delete();
        expected.push_back(make_wr(rows[idx].store, want.a));
        expected.push_back(make_wr({`CPU_STACK_BASE, 8'hFF}, want.p));
        expected.push_back(make_wr({`CPU_STACK_BASE, 8'hFE}, want.p));
        compare_writes(idx);
        rows_run++;
        $display("Row %0d opcode %h load %h operand %h stall %0d: %s", idx,
                 rows[idx].opc, rows[idx].load, rows[idx].operand, rows[idx].stall,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst      = 1'b1;
        rdy      = 1'b1;
        stall_on = 1'b0;
        checks   = 0;
        errors   = 0;
        rows_run = 0;
        // Background pattern from both address bytes
        for (int i = 0; i < 65536; i++) mem[i] = i[15:8] ^ i[7:0];
        load_table();
        for (int i = 0; i < NUM_ROWS; i++) build_row(i);
        for (int i = 0; i < NUM_ROWS; i++) run_row(i);
        $display("Rows run %0d, checks %0d, errors %0d", rows_run, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/cpu_chk.sv
// Bus protocol assertions for cpu_top
// Bound into the core from the testbench; watches fetch/write exclusion,
// the held bus during rdy stalls and the quiet bus out of reset
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_chk (
    input logic                       phi0,
    input logic                       rst,
    input logic                       rdy,
    input logic [`CPU_ADDR_WIDTH-1:0] a,
    input logic [`CPU_REG_WIDTH-1:0]  d_out,
    input logic                       r_w_n,
    input logic                       sync
);

    // An opcode fetch is always a read
    fetch_is_read: assert property (
        @(posedge phi0) disable iff (rst) !(sync && !r_w_n)
    ) else $error("write strobe high during an opcode fetch");

    // A stalled cycle is repeated unchanged
    stall_holds_bus: assert property (
        @(posedge phi0) disable iff (rst)
        !rdy |=> ($stable(a) && $stable(d_out) && $stable(r_w_n) && $stable(sync))
    ) else $error("bus outputs changed while rdy was low");

    // Reset leaves a read cycle with no fetch
    reset_quiet: assert property (
        @(posedge phi0) rst |=> (r_w_n && !sync)
    ) else $error("bus not quiet in the cycle after reset");

endmodule

// File: verilog/cpu_top.sv
// Top level of the 6502-style core
// Connects sequencer, decoder, ALU and registers to a split-data memory bus;
// memory must return d_in in the same cycle as a
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
    input  logic                        phi0,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic [`CPU_REG_WIDTH-1:0]   d_in,
    output logic [`CPU_ADDR_WIDTH-1:0]  a,
    output logic [`CPU_REG_WIDTH-1:0]   d_out,
    output logic                        r_w_n,
    output logic                        sync
);

    cpu_pkg::opcode_t          opcode;
    cpu_pkg::ctrl_t            ctrl;
    cpu_pkg::status_t          status;
    cpu_pkg::status_t          alu_status;
    bus_pkg::bus_req_t         bus;
    logic [`CPU_REG_WIDTH-1:0] operand;
    logic [`CPU_REG_WIDTH-1:0] alu_a;
    logic [`CPU_REG_WIDTH-1:0] alu_result;
    logic [`CPU_REG_WIDTH-1:0] a_reg;
    logic [`CPU_REG_WIDTH-1:0] x_reg;
    logic [`CPU_REG_WIDTH-1:0] y_reg;
    logic [`CPU_REG_WIDTH-1:0] sp;
    logic                      alu_cin;
    logic                      exec_we;
    logic                      sp_dec;

    // Pins
    assign a     = bus.addr;
    assign d_out = bus.wdata;
    assign r_w_n = ~bus.write;
    assign sync  = bus.sync;

    sequencer u_seq (
        .phi0(phi0), .rst(rst), .rdy(rdy), .d_in(d_in), .ctrl(ctrl),
        .alu_result(alu_result), .sp(sp), .a_reg(a_reg), .x_reg(x_reg),
        .y_reg(y_reg), .status(status), .opcode(opcode), .operand(operand),
        .alu_a(alu_a), .alu_cin(alu_cin), .exec_we(exec_we), .sp_dec(sp_dec),
        .bus(bus)
    );

    decoder u_dec (.opcode(opcode), .ctrl(ctrl));

    alu u_alu (
        .op(ctrl.alu_op), .a(alu_a), .b(operand), .carry_in(alu_cin),
        .status_in(status), .result(alu_result), .status_out(alu_status)
    );

    reg_file u_regs (
        .phi0(phi0), .rst(rst), .rdy(rdy), .exec_we(exec_we), .sp_dec(sp_dec),
        .ctrl(ctrl), .result(alu_result), .status_new(alu_status),
        .a_reg(a_reg), .x_reg(x_reg), .y_reg(y_reg), .sp(sp), .status(status)
    );

endmodule

// File: verilog/sequencer.sv
// Fetch and bus sequencer
// Holds PC and opcode, steps each instruction through its bus cycles and
// picks the ALU operands; one bus cycle per phi0 edge while rdy is high
`timescale 1ns/1ps
`include "cpu_defs.svh"

module sequencer (
    input  logic                        phi0,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic [`CPU_REG_WIDTH-1:0]   d_in,
    input  cpu_pkg::ctrl_t              ctrl,
    input  logic [`CPU_REG_WIDTH-1:0]   alu_result,
    input  logic [`CPU_REG_WIDTH-1:0]   sp,
    input  logic [`CPU_REG_WIDTH-1:0]   a_reg,
    input  logic [`CPU_REG_WIDTH-1:0]   x_reg,
    input  logic [`CPU_REG_WIDTH-1:0]   y_reg,
    input  cpu_pkg::status_t            status,
    output cpu_pkg::opcode_t            opcode,
    output logic [`CPU_REG_WIDTH-1:0]   operand,
    output logic [`CPU_REG_WIDTH-1:0]   alu_a,
    output logic                        alu_cin,
    output logic                        exec_we,
    output logic                        sp_dec,
    output bus_pkg::bus_req_t           bus
);

    // IDLE is the quiet cycle out of reset
    typedef enum logic [2:0] {ST_IDLE, ST_FETCH, ST_T1, ST_T2, ST_T3} state_t;

    state_t                     state;
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    logic [`CPU_REG_WIDTH-1:0]  lo_q;
    logic [`CPU_REG_WIDTH-1:0]  hi_q;
    cpu_pkg::reg_sel_t          src_sel;
    bus_pkg::addr_sel_t         addr_sel;
    cpu_pkg::status_t           push_status;
    logic                       push_cyc;

    ////////////////////////////////////////////////////////////
    // ALU operands
    ////////////////////////////////////////////////////////////

    // Stores route their register through the ALU as a move
    assign src_sel = (ctrl.cls == cpu_pkg::CLS_ABS_STORE) ? ctrl.st_src : ctrl.a_sel;
    assign operand = (ctrl.b_sel == cpu_pkg::B_OPERAND) ? d_in : '0;

    always_comb begin
        case (src_sel)
            cpu_pkg::REG_A: alu_a = a_reg;
            cpu_pkg::REG_X: alu_a = x_reg;
            cpu_pkg::REG_Y: alu_a = y_reg;
            default:        alu_a = '0;
        endcase
        case (ctrl.cin_sel)
            cpu_pkg::CIN_FLAG: alu_cin = status.c;
            cpu_pkg::CIN_ONE:  alu_cin = 1'b1;
            default:           alu_cin = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Bus request
    ////////////////////////////////////////////////////////////

    assign push_cyc = (state == ST_T2) && (ctrl.cls == cpu_pkg::CLS_PUSH);
    assign sp_dec   = push_cyc;
    assign exec_we  = (state == ST_T1) && (ctrl.cls == cpu_pkg::CLS_IMPLIED ||
                                           ctrl.cls == cpu_pkg::CLS_IMMEDIATE);

    always_comb begin
        push_status     = status;
        push_status.b   = 1'b1;
        push_status.one = 1'b1;

        addr_sel  = bus_pkg::ADDR_PC;
        bus.write = 1'b0;
        bus.wdata = alu_result;
        bus.sync  = (state == ST_FETCH);
        if (state == ST_T3) begin
            addr_sel  = bus_pkg::ADDR_ABS;
            bus.write = 1'b1;
        end else if (push_cyc) begin
            addr_sel  = bus_pkg::ADDR_STACK;
            bus.write = 1'b1;
            bus.wdata = push_status;
        end

        case (addr_sel)
            bus_pkg::ADDR_ABS:   bus.addr = {hi_q, lo_q};
            bus_pkg::ADDR_STACK: bus.addr = {`CPU_STACK_BASE, sp};
            default:             bus.addr = pc;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Cycle state machine and PC
    ////////////////////////////////////////////////////////////

    always_ff @(posedge phi0) begin
        if (rst) begin
            state      <= ST_IDLE;
            pc         <= `CPU_RESET_PC;
            opcode.raw <= 8'hEA;
        end else if (rdy) begin
            case (state)
                ST_IDLE: state <= ST_FETCH;
                ST_FETCH: begin
                    opcode <= d_in;
                    pc     <= pc + 1'b1;
                    state  <= ST_T1;
                end
                ST_T1: begin
                    // Implied and push read the next byte and discard it
                    if (ctrl.cls == cpu_pkg::CLS_IMPLIED) begin
                        state <= ST_FETCH;
                    end else if (ctrl.cls == cpu_pkg::CLS_PUSH) begin
                        state <= ST_T2;
                    end else begin
                        pc    <= pc + 1'b1;
                        state <= (ctrl.cls == cpu_pkg::CLS_IMMEDIATE) ? ST_FETCH : ST_T2;
                    end
                end
                ST_T2: begin
                    if (ctrl.cls == cpu_pkg::CLS_JUMP) begin
                        pc    <= {d_in, lo_q};
                        state <= ST_FETCH;
                    end else if (ctrl.cls == cpu_pkg::CLS_ABS_STORE) begin
                        pc    <= pc + 1'b1;
                        state <= ST_T3;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // Absolute address bytes
    always_ff @(posedge phi0) begin
        if (rdy && state == ST_T1) lo_q <= d_in;
        if (rdy && state == ST_T2) hi_q <= d_in;
    end

endmodule

// File: verilog/reg_file.sv
// Programmer-visible registers: A, X, Y, stack pointer and status
// Written in the execute cycle on exec_we; SP steps down on sp_dec
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file (
    input  logic                        phi0,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        exec_we,
    input  logic                        sp_dec,
    input  cpu_pkg::ctrl_t              ctrl,
    input  logic [`CPU_REG_WIDTH-1:0]   result,
    input  cpu_pkg::status_t            status_new,
    output logic [`CPU_REG_WIDTH-1:0]   a_reg,
    output logic [`CPU_REG_WIDTH-1:0]   x_reg,
    output logic [`CPU_REG_WIDTH-1:0]   y_reg,
    output logic [`CPU_REG_WIDTH-1:0]   sp,
    output cpu_pkg::status_t            status
);

    localparam cpu_pkg::status_t STATUS_RESET = '{n: 1'b0, v: 1'b0, one: 1'b1, b: 1'b0,
                                                  d: 1'b0, i: 1'b1, z: 1'b0, c: 1'b0};

    cpu_pkg::status_t status_next;

    // Merge only the flags this instruction owns
    always_comb begin
        status_next = status;
        if (ctrl.upd_nz) begin
            status_next.n = status_new.n;
            status_next.z = status_new.z;
        end
        if (ctrl.upd_v) status_next.v = status_new.v;
        if (ctrl.upd_c) status_next.c = status_new.c;
        if (ctrl.set_c) status_next.c = 1'b1;
        if (ctrl.clr_c) status_next.c = 1'b0;
    end

    always_ff @(posedge phi0) begin
        if (rst) begin
            a_reg  <= '0;
            x_reg  <= '0;
            y_reg  <= '0;
            sp     <= `CPU_RESET_SP;
            status <= STATUS_RESET;
        end else if (rdy) begin
            if (exec_we) begin
                status <= status_next;
                case (ctrl.dest)
                    cpu_pkg::REG_A: a_reg <= result;
                    cpu_pkg::REG_X: x_reg <= result;
                    cpu_pkg::REG_Y: y_reg <= result;
                    default: ;
                endcase
            end
            if (sp_dec) sp <= sp - 1'b1;
        end
    end

endmodule

// File: verilog/alu.sv
// 8-bit ALU, binary mode only
// Returns the result and a status word with N, Z and, for add and subtract, C and V
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
    input  cpu_pkg::alu_op_t            op,
    input  logic [`CPU_REG_WIDTH-1:0]   a,
    input  logic [`CPU_REG_WIDTH-1:0]   b,
    input  logic                        carry_in,
    input  cpu_pkg::status_t            status_in,
    output logic [`CPU_REG_WIDTH-1:0]   result,
    output cpu_pkg::status_t            status_out
);

    logic [`CPU_REG_WIDTH-1:0] b_eff;
    logic [`CPU_REG_WIDTH:0]   sum;
    logic                      is_sub;

    // Subtract and compare add the inverted operand
    assign is_sub = (op == cpu_pkg::ALU_SUB) || (op == cpu_pkg::ALU_CMP);
    assign b_eff  = is_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{`CPU_REG_WIDTH{1'b0}}, carry_in};

    always_comb begin
        status_out = status_in;
        case (op)
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: begin
                result       = sum[`CPU_REG_WIDTH-1:0];
                status_out.c = sum[`CPU_REG_WIDTH];
                // Overflow when both inputs share a sign the result lacks
                status_out.v = (a[`CPU_REG_WIDTH-1] == b_eff[`CPU_REG_WIDTH-1]) &&
                               (sum[`CPU_REG_WIDTH-1] != a[`CPU_REG_WIDTH-1]);
            end
            cpu_pkg::ALU_CMP: begin
                result       = sum[`CPU_REG_WIDTH-1:0];
                status_out.c = sum[`CPU_REG_WIDTH];
            end
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_XOR: result = a ^ b;
            cpu_pkg::ALU_INC: result = a + 1'b1;
            cpu_pkg::ALU_DEC: result = a - 1'b1;
            // Moves and OR; the unused operand reads as zero
            default: result = a | b;
        endcase
        status_out.n = result[`CPU_REG_WIDTH-1];
        status_out.z = (result == '0);
    end

endmodule

// File: verilog/decoder.sv
// Opcode decoder
// Turns the held opcode into a control struct, combinationally
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::opcode_t opcode,
    output cpu_pkg::ctrl_t   ctrl
);

    cpu_pkg::reg_sel_t idx_reg;

    // cc=10 is the X group, cc=00 the Y group
    assign idx_reg = (opcode.f.cc == 2'b10) ? cpu_pkg::REG_X : cpu_pkg::REG_Y;

    always_comb begin
        ctrl.cls     = cpu_pkg::CLS_IMPLIED;
        ctrl.alu_op  = cpu_pkg::ALU_PASS;
        ctrl.a_sel   = cpu_pkg::REG_A;
        ctrl.b_sel   = cpu_pkg::B_NONE;
        ctrl.cin_sel = cpu_pkg::CIN_ZERO;
        ctrl.dest    = cpu_pkg::REG_NONE;
        ctrl.upd_nz  = 1'b0;
        ctrl.upd_c   = 1'b0;
        ctrl.upd_v   = 1'b0;
        ctrl.set_c   = 1'b0;
        ctrl.clr_c   = 1'b0;
        ctrl.st_src  = cpu_pkg::REG_A;

        case (opcode.raw)
            8'hAA: begin ctrl.a_sel = cpu_pkg::REG_A; ctrl.dest = cpu_pkg::REG_X; end
            8'hA8: begin ctrl.a_sel = cpu_pkg::REG_A; ctrl.dest = cpu_pkg::REG_Y; end
            8'h8A: begin ctrl.a_sel = cpu_pkg::REG_X; ctrl.dest = cpu_pkg::REG_A; end
            8'h98: begin ctrl.a_sel = cpu_pkg::REG_Y; ctrl.dest = cpu_pkg::REG_A; end
            8'hE8, 8'hCA: begin
                ctrl.a_sel  = cpu_pkg::REG_X;
                ctrl.dest   = cpu_pkg::REG_X;
                ctrl.alu_op = opcode.raw[5] ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
            end
            8'hC8, 8'h88: begin
                ctrl.a_sel  = cpu_pkg::REG_Y;
                ctrl.dest   = cpu_pkg::REG_Y;
                ctrl.alu_op = opcode.raw[6] ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
            end
            8'h18: ctrl.clr_c = 1'b1;
            8'h38: ctrl.set_c = 1'b1;
            8'h08: ctrl.cls = cpu_pkg::CLS_PUSH;
            8'h4C: ctrl.cls = cpu_pkg::CLS_JUMP;
            8'hEA: ctrl.cls = cpu_pkg::CLS_IMPLIED;
            default: begin
                case (opcode.f.cc)
                    // ALU group, immediate when bbb=010
                    2'b01: begin
                        if (opcode.f.bbb == 3'b010 && opcode.f.aaa != 3'b100) begin
                            ctrl.cls    = cpu_pkg::CLS_IMMEDIATE;
                            ctrl.b_sel  = cpu_pkg::B_OPERAND;
                            ctrl.dest   = cpu_pkg::REG_A;
                            case (opcode.f.aaa)
                                3'b000: ctrl.alu_op = cpu_pkg::ALU_OR;
                                3'b001: ctrl.alu_op = cpu_pkg::ALU_AND;
                                3'b010: ctrl.alu_op = cpu_pkg::ALU_XOR;
                                3'b011: begin
                                    ctrl.alu_op  = cpu_pkg::ALU_ADD;
                                    ctrl.cin_sel = cpu_pkg::CIN_FLAG;
                                    ctrl.upd_c   = 1'b1;
                                    ctrl.upd_v   = 1'b1;
                                end
                                3'b110: begin
                                    ctrl.alu_op  = cpu_pkg::ALU_CMP;
                                    ctrl.cin_sel = cpu_pkg::CIN_ONE;
                                    ctrl.dest    = cpu_pkg::REG_NONE;
                                    ctrl.upd_c   = 1'b1;
                                end
                                3'b111: begin
                                    ctrl.alu_op  = cpu_pkg::ALU_SUB;
                                    ctrl.cin_sel = cpu_pkg::CIN_FLAG;
                                    ctrl.upd_c   = 1'b1;
                                    ctrl.upd_v   = 1'b1;
                                end
                                // LDA
                                default: ctrl.a_sel = cpu_pkg::REG_NONE;
                            endcase
                        end else if (opcode.f.aaa == 3'b100 && opcode.f.bbb == 3'b011) begin
                            ctrl.cls = cpu_pkg::CLS_ABS_STORE;
                        end
                    end
                    // LDX/STX and LDY/STY
                    2'b10, 2'b00: begin
                        if (opcode.f.aaa == 3'b101 && opcode.f.bbb == 3'b000) begin
                            ctrl.cls   = cpu_pkg::CLS_IMMEDIATE;
                            ctrl.b_sel = cpu_pkg::B_OPERAND;
                            ctrl.a_sel = cpu_pkg::REG_NONE;
                            ctrl.dest  = idx_reg;
                        end else if (opcode.f.aaa == 3'b100 && opcode.f.bbb == 3'b011) begin
                            ctrl.cls    = cpu_pkg::CLS_ABS_STORE;
                            ctrl.st_src = idx_reg;
                        end
                    end
                    default: ctrl.cls = cpu_pkg::CLS_IMPLIED;
                endcase
            end
        endcase

        // Anything that writes a register sets N and Z
        if (ctrl.dest != cpu_pkg::REG_NONE || ctrl.alu_op == cpu_pkg::ALU_CMP) begin
            ctrl.upd_nz = 1'b1;
        end
    end

endmodule

// File: verilog/bus_pkg.sv
// Memory bus types for the core
// The sequencer builds a bus_req_t each cycle and the top level drives the pins
`include "cpu_defs.svh"

package bus_pkg;

    // One bus cycle as seen at the pins
    typedef struct packed {
        logic [`CPU_ADDR_WIDTH-1:0] addr;
        logic [`CPU_REG_WIDTH-1:0]  wdata;
        logic                       write;
        logic                       sync;
    } bus_req_t;

    // Address source for the current cycle
    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_ABS,
        ADDR_STACK
    } addr_sel_t;

endpackage

// File: verilog/cpu_pkg.sv
// Instruction-level types for the core
// Shared by decoder, ALU, register file and sequencer through cpu_pkg:: names
`include "cpu_defs.svh"

package cpu_pkg;

    // 6502 opcode split as aaa bbb cc
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    // One opcode byte, read raw or as fields
    typedef union packed {
        logic [`CPU_REG_WIDTH-1:0] raw;
        opcode_fields_t            f;
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_CMP, ALU_INC, ALU_DEC
    } alu_op_t;

    // Processor status register, 6502 bit order
    typedef struct packed {
        logic n;
        logic v;
        logic one;
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } status_t;

    typedef enum logic [2:0] {
        CLS_IMPLIED, CLS_IMMEDIATE, CLS_ABS_STORE, CLS_JUMP, CLS_PUSH
    } inst_class_t;

    // Register selector, NONE reads as zero
    typedef enum logic [1:0] {REG_A, REG_X, REG_Y, REG_NONE} reg_sel_t;
    typedef enum logic {B_OPERAND, B_NONE} b_sel_t;
    typedef enum logic [1:0] {CIN_FLAG, CIN_ZERO, CIN_ONE} cin_sel_t;

    typedef struct packed {
        inst_class_t cls;
        alu_op_t     alu_op;
        reg_sel_t    a_sel;
        b_sel_t      b_sel;
        cin_sel_t    cin_sel;
        reg_sel_t    dest;
        logic        upd_nz;
        logic        upd_c;
        logic        upd_v;
        logic        set_c;
        logic        clr_c;
        reg_sel_t    st_src;
    } ctrl_t;

endpackage

// File: verilog/cpu_defs.svh
// Global widths and reset constants for the 6502-style core
// Included by the packages and by each RTL file that sizes a bus or a register
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Bus and register widths
`define CPU_ADDR_WIDTH 16
`define CPU_REG_WIDTH  8

// State after reset
`define CPU_RESET_PC   16'h0200
`define CPU_RESET_SP   8'hFF

// Stack lives in page one
`define CPU_STACK_BASE 8'h01

`endif
